//--- tb.f
+incdir+rtl
rtl/rx_intf_pkg.sv
rtl/rx_sync_fifo.sv
rtl/rx_intf_s_axis.sv
rtl/rx_intf_wb_regs.sv
rtl/rx_iq_combiner.sv
rtl/rx_intf.sv
test/rx_intf_chk.sv
test/rx_intf_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rx_intf_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_FLAGS ?= -Wno-fatal
PASS_STR  ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/rx_intf_tb.sv
/* Testbench: clock, reset, LCG stimulus, Wishbone tasks, combiner model and checks. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_intf_tb;

	logic                    S_AXIS_ACLK;
	logic                    S_AXIS_ARESETN;
	rx_intf_pkg::rx_word_t   s0_tdata;
	logic [`RX_DATA_W/8-1:0] s0_tstrb;
	logic                    s0_tlast;
	logic                    s0_tvalid;
	logic                    s0_tready;
	rx_intf_pkg::rx_word_t   s1_tdata;
	logic [`RX_DATA_W/8-1:0] s1_tstrb;
	logic                    s1_tlast;
	logic                    s1_tvalid;
	logic                    s1_tready;
	rx_intf_pkg::rx_word_t   data_to_acc;
	logic                    emptyn_to_acc;
	logic                    acc_ask_data;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [3:0]              wb_adr;
	logic [31:0]             wb_dat_w;
	logic [31:0]             wb_dat_r;
	logic                    wb_ack;

	logic [31:0]           rng;
	logic [`RX_DATA_W-1:0] q0[$];
	logic [`RX_DATA_W-1:0] q1[$];
	logic [`RX_DATA_W-1:0] bdata [2][32];
	int                    bgap [2][32];
	int                    consumed;
	int                    run0;
	int                    run1;
	int                    len;
	logic [31:0]           rd;
	bit                    verdict_shown;

	rx_intf i_rx_intf (.*);

	initial
	begin
		S_AXIS_ACLK = 1'b0;
		forever #4 S_AXIS_ACLK = ~S_AXIS_ACLK;
	end

	function automatic logic [31:0] lcg();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// Lane-wise average of two antennas, rounded toward minus infinity.
	function automatic logic [`RX_DATA_W-1:0] avg_model(input logic [`RX_DATA_W-1:0] x,
		input logic [`RX_DATA_W-1:0] y);
		int                    l;
		int                    s;
		logic [`RX_DATA_W-1:0] r;
		for (l = 0; l < rx_intf_pkg::LANES; l++)
		begin
			s = int'($signed(x[l*16 +: 16])) + int'($signed(y[l*16 +: 16]));
			if (s < 0 && (s % 2) != 0)
				s = s - 1;
			s = s / 2;
			r[l*16 +: 16] = s[15:0];
		end
		return r;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		verdict_shown = 1'b1;
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
		int n;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = dat;
		n = 0;
		do
		begin
			@(negedge S_AXIS_ACLK);
			n++;
			if (n > 20)
				abort_run("timed out waiting for wb_ack on a register write");
		end
		while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		n = 0;
		do
		begin
			@(negedge S_AXIS_ACLK);
			n++;
			if (n > 20)
				abort_run("timed out waiting for wb_ack on a register read");
		end
		while (!wb_ack);
		dat    = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic drive_beat(input int p, input logic v, input logic [63:0] d, input logic l);
		if (p == 0)
		begin
			s0_tvalid = v;
			s0_tdata  = d;
			s0_tlast  = l;
		end
		else
		begin
			s1_tvalid = v;
			s1_tdata  = d;
			s1_tlast  = l;
		end
	endtask

	// Same lengths on both ports, first beat optionally at the lane extremes.
	task automatic prep_bursts(input int n, input bit gaps, input bit extreme);
		int          i;
		int          p;
		logic [31:0] hi;
		logic [31:0] lo;
		for (i = 0; i < n; i++)
			for (p = 0; p < 2; p++)
			begin
				hi = lcg();
				lo = lcg();
				bdata[p][i] = {hi, lo};
				bgap[p][i]  = gaps ? int'((lcg() >> 16) % 3) : 0;
			end
		if (extreme)
		begin
			bdata[0][0] = 64'h7fff_8000_8000_7fff;
			bdata[1][0] = 64'h8000_7fff_7fff_8000;
		end
	endtask

	// Run is the number of beats accepted before the first stall after the burst opened.
	task automatic send_burst(input int p, input int n, input bit last_on, output int run);
		int i;
		int waited;
		int accepted;
		bit got;
		bit stalled;
		accepted = 0;
		stalled  = 1'b0;
		run      = n;
		for (i = 0; i < n; i++)
		begin
			repeat (bgap[p][i])
				@(negedge S_AXIS_ACLK);
			drive_beat(p, 1'b1, bdata[p][i], last_on && (i == n - 1));
			waited = 0;
			got    = 1'b0;
			while (!got)
			begin
				@(posedge S_AXIS_ACLK);
				got = (p == 0) ? s0_tready : s1_tready;
				if (!got && accepted > 0 && !stalled)
				begin
					stalled = 1'b1;
					run     = accepted;
				end
				waited++;
				if (waited > 300)
					abort_run($sformatf("timed out waiting for tready on port %0d", p));
			end
			accepted++;
			@(negedge S_AXIS_ACLK);
			drive_beat(p, 1'b0, '0, 1'b0);
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (q0.size() != 0 || q1.size() != 0)
		begin
			@(negedge S_AXIS_ACLK);
			n++;
			if (n > 500)
				abort_run("timed out waiting for the accelerator to take every word");
		end
	endtask

	// Keep the accelerator stalled until both FIFOs and the output register are full.
	task automatic hold_then_drain();
		int n;
		n = 0;
		while (q0.size() < `RX_FIFO_DEPTH + 1 || q1.size() < `RX_FIFO_DEPTH + 1)
		begin
			@(negedge S_AXIS_ACLK);
			n++;
			if (n > 200)
				abort_run("timed out waiting for both antenna FIFOs to fill");
		end
		repeat (8)
		begin
			@(negedge S_AXIS_ACLK);
			check_eq("s0_tready", s0_tready, 0);
			check_eq("s1_tready", s1_tready, 0);
			check_eq("emptyn_to_acc", emptyn_to_acc, 1);
		end
		check_eq("beats held on port 0", q0.size(), `RX_FIFO_DEPTH + 1);
		check_eq("beats held on port 1", q1.size(), `RX_FIFO_DEPTH + 1);
		acc_ask_data = 1'b1;
	endtask

	always @(posedge S_AXIS_ACLK)
	begin
		if (s0_tvalid && s0_tready)
			q0.push_back(s0_tdata);
		if (s1_tvalid && s1_tready)
			q1.push_back(s1_tdata);
		if (emptyn_to_acc && acc_ask_data)
		begin
			if (q0.size() == 0 || q1.size() == 0)
				abort_run("accelerator took a word that no accepted beat pair explains");
			else
			begin
				check_eq("data_to_acc", data_to_acc, avg_model(q0.pop_front(), q1.pop_front()));
				consumed++;
			end
		end
	end

	initial
	begin
		rng            = 32'hd93f;
		consumed       = 0;
		verdict_shown  = 1'b0;
		S_AXIS_ARESETN = 1'b0;
		s0_tdata       = '0;
		s0_tstrb       = '1;
		s0_tlast       = 1'b0;
		s0_tvalid      = 1'b0;
		s1_tdata       = '0;
		s1_tstrb       = '1;
		s1_tlast       = 1'b0;
		s1_tvalid      = 1'b0;
		acc_ask_data   = 1'b0;
		wb_cyc         = 1'b0;
		wb_stb         = 1'b0;
		wb_we          = 1'b0;
		wb_adr         = '0;
		wb_dat_w       = '0;
		repeat (16)
			@(negedge S_AXIS_ACLK);
		S_AXIS_ARESETN = 1'b1;
		@(negedge S_AXIS_ACLK);

		// Outputs are quiet right after reset.
		check_eq("s0_tready", s0_tready, 0);
		check_eq("s1_tready", s1_tready, 0);
		check_eq("emptyn_to_acc", emptyn_to_acc, 0);
		check_eq("wb_ack", wb_ack, 0);

		wb_read(`RX_REG_CTRL, rd);
		check_eq("CTRL", rd, 0);
		wb_read(`RX_REG_NUM_SYM, rd);
		check_eq("NUM_SYM", rd, 0);
		wb_read(`RX_REG_DELIVERED, rd);
		check_eq("DELIVERED", rd, 0);
		wb_write(`RX_REG_NUM_SYM, 32'h2a5b);
		wb_read(`RX_REG_NUM_SYM, rd);
		check_eq("NUM_SYM", rd, 32'h2a5b);
		wb_write(`RX_REG_CTRL, 32'h1);
		wb_read(`RX_REG_CTRL, rd);
		check_eq("CTRL", rd, 32'h1);
		wb_read(4'hf, rd);
		check_eq("unmapped register", rd, 0);

		// Random bursts closed by tlast.
		wb_write(`RX_REG_CTRL, 32'h0);
		wb_write(`RX_REG_NUM_SYM, 32'd64);
		acc_ask_data = 1'b1;
		repeat (6)
		begin
			len = 1 + int'((lcg() >> 16) % 8);
			prep_bursts(len, 1'b1, 1'b1);
			fork
				send_burst(0, len, 1'b1, run0);
				send_burst(1, len, 1'b1, run1);
			join
		end
		wait_drained();

		wb_write(`RX_REG_NUM_SYM, 32'd5);
		prep_bursts(8, 1'b0, 1'b0);
		fork
			send_burst(0, 8, 1'b0, run0);
			send_burst(1, 8, 1'b0, run1);
		join
		check_eq("s0 beats before first stall", run0, 5);
		check_eq("s1 beats before first stall", run1, 5);
		wait_drained();

		wb_write(`RX_REG_CTRL, 32'h1);
		prep_bursts(12, 1'b0, 1'b0);
		fork
			send_burst(0, 12, 1'b1, run0);
			send_burst(1, 12, 1'b1, run1);
		join
		check_eq("s0 beats in endless burst", run0, 12);
		check_eq("s1 beats in endless burst", run1, 12);
		wait_drained();

		acc_ask_data = 1'b0;
		prep_bursts(24, 1'b0, 1'b1);
		fork
			send_burst(0, 24, 1'b1, run0);
			send_burst(1, 24, 1'b1, run1);
			hold_then_drain();
		join
		wait_drained();

		wb_read(`RX_REG_DELIVERED, rd);
		check_eq("DELIVERED", rd, consumed);
		wb_write(`RX_REG_DELIVERED, 32'hffff_ffff);
		wb_read(`RX_REG_DELIVERED, rd);
		check_eq("DELIVERED", rd, 0);

		verdict_shown = 1'b1;
		$display("Result: PASSED");
		$finish;
	end

	// A run stopped by a bound assertion ends here without a verdict.
	final
	begin
		if (!verdict_shown)
			$display("Result: FAILED");
	end

endmodule

//--- test/rx_intf_chk.sv
/* Bound assertions on the stream, FIFO and Wishbone handshakes. */

`timescale 1ns/1ps

module rx_intf_chk
(
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input logic s0_tready,
	input logic s1_tready,
	input logic fifo0_full,
	input logic fifo1_full,
	input logic fifo0_empty,
	input logic fifo1_empty,
	input logic fifo0_rd_en,
	input logic fifo1_rd_en,
	input logic wb_ack
);
	a_s0_full: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(s0_tready && fifo0_full))
		else $error("s0_tready high while FIFO 0 is full");

	a_s1_full: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(s1_tready && fifo1_full))
		else $error("s1_tready high while FIFO 1 is full");

	// Ack is a single-cycle pulse.
	a_ack_pulse: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	a_rd0_empty: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(fifo0_rd_en && fifo0_empty))
		else $error("FIFO 0 read while empty");

	a_rd1_empty: assert property (@(posedge S_AXIS_ACLK) disable iff (!S_AXIS_ARESETN)
		!(fifo1_rd_en && fifo1_empty))
		else $error("FIFO 1 read while empty");

endmodule

bind rx_intf rx_intf_chk i_chk (
	.S_AXIS_ACLK,
	.S_AXIS_ARESETN,
	.s0_tready,
	.s1_tready,
	.fifo0_full,
	.fifo1_full,
	.fifo0_empty,
	.fifo1_empty,
	.fifo0_rd_en,
	.fifo1_rd_en,
	.wb_ack
);

//--- rtl/rx_intf.sv
/* Receive interface top: two AXI-Stream slaves, their FIFOs, the combiner and registers. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_intf
(
	input  logic                    S_AXIS_ACLK,
	input  logic                    S_AXIS_ARESETN,
	input  rx_intf_pkg::rx_word_t   s0_tdata,
	input  logic [`RX_DATA_W/8-1:0] s0_tstrb,
	input  logic                    s0_tlast,
	input  logic                    s0_tvalid,
	output logic                    s0_tready,
	input  rx_intf_pkg::rx_word_t   s1_tdata,
	input  logic [`RX_DATA_W/8-1:0] s1_tstrb,
	input  logic                    s1_tlast,
	input  logic                    s1_tvalid,
	output logic                    s1_tready,
	output rx_intf_pkg::rx_word_t   data_to_acc,
	output logic                    emptyn_to_acc,
	input  logic                    acc_ask_data,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [3:0]              wb_adr,
	input  logic [31:0]             wb_dat_w,
	output logic [31:0]             wb_dat_r,
	output logic                    wb_ack
);
	logic                  endless_mode;
	logic [`RX_CNT_W-1:0]  num_dma_symbol;
	logic                  word_taken;

	logic                  fifo0_wren;
	logic                  fifo1_wren;
	rx_intf_pkg::rx_word_t fifo0_din;
	rx_intf_pkg::rx_word_t fifo1_din;
	rx_intf_pkg::rx_word_t fifo0_dout;
	rx_intf_pkg::rx_word_t fifo1_dout;
	logic                  fifo0_rd_en;
	logic                  fifo1_rd_en;
	logic                  fifo0_empty;
	logic                  fifo1_empty;
	logic                  fifo0_full;
	logic                  fifo1_full;

	rx_intf_wb_regs i_wb_regs (
		.S_AXIS_ACLK, .S_AXIS_ARESETN,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .word_taken,
		.wb_dat_r, .wb_ack, .endless_mode, .num_dma_symbol
	);

	// Both antennas share one burst configuration.
	rx_intf_s_axis i_s_axis0 (
		.S_AXIS_ACLK, .S_AXIS_ARESETN, .endless_mode, .num_dma_symbol,
		.tdata(s0_tdata), .tstrb(s0_tstrb), .tlast(s0_tlast), .tvalid(s0_tvalid),
		.fifo_full(fifo0_full), .tready(s0_tready),
		.fifo_wren(fifo0_wren), .fifo_din(fifo0_din)
	);

	rx_intf_s_axis i_s_axis1 (
		.S_AXIS_ACLK, .S_AXIS_ARESETN, .endless_mode, .num_dma_symbol,
		.tdata(s1_tdata), .tstrb(s1_tstrb), .tlast(s1_tlast), .tvalid(s1_tvalid),
		.fifo_full(fifo1_full), .tready(s1_tready),
		.fifo_wren(fifo1_wren), .fifo_din(fifo1_din)
	);

	rx_sync_fifo #(.DEPTH(`RX_FIFO_DEPTH), .WIDTH(`RX_DATA_W)) i_fifo0 (
		.S_AXIS_ACLK, .S_AXIS_ARESETN,
		.wr_en(fifo0_wren), .din(fifo0_din), .rd_en(fifo0_rd_en),
		.dout(fifo0_dout), .empty(fifo0_empty), .full(fifo0_full), .data_count()
	);

	rx_sync_fifo #(.DEPTH(`RX_FIFO_DEPTH), .WIDTH(`RX_DATA_W)) i_fifo1 (
		.S_AXIS_ACLK, .S_AXIS_ARESETN,
		.wr_en(fifo1_wren), .din(fifo1_din), .rd_en(fifo1_rd_en),
		.dout(fifo1_dout), .empty(fifo1_empty), .full(fifo1_full), .data_count()
	);

	rx_iq_combiner i_combiner (
		.S_AXIS_ACLK, .S_AXIS_ARESETN,
		.a0_dout(fifo0_dout), .a0_empty(fifo0_empty),
		.a1_dout(fifo1_dout), .a1_empty(fifo1_empty),
		.acc_ask_data, .a0_rd_en(fifo0_rd_en), .a1_rd_en(fifo1_rd_en),
		.data_to_acc, .emptyn_to_acc, .word_taken
	);

endmodule

//--- rtl/rx_iq_combiner.sv
/* Two-antenna lockstep pop, lane-wise average and output register. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_iq_combiner
(
	input  logic                  S_AXIS_ACLK,
	input  logic                  S_AXIS_ARESETN,
	input  rx_intf_pkg::rx_word_t a0_dout,
	input  logic                  a0_empty,
	input  rx_intf_pkg::rx_word_t a1_dout,
	input  logic                  a1_empty,
	input  logic                  acc_ask_data,
	output logic                  a0_rd_en,
	output logic                  a1_rd_en,
	output rx_intf_pkg::rx_word_t data_to_acc,
	output logic                  emptyn_to_acc,
	output logic                  word_taken
);
	logic [`RX_DATA_W-1:0] a0_flat;
	logic [`RX_DATA_W-1:0] a1_flat;
	logic [`RX_DATA_W-1:0] avg_word;
	logic                  out_valid;
	logic                  drain;
	logic                  load;

	assign a0_flat = a0_dout;
	assign a1_flat = a1_dout;

	// floor((a+b)/2) on a 17-bit sum never overflows.
	for (genvar l = 0; l < rx_intf_pkg::LANES; l++)
	begin : g_lane
		rx_intf_pkg::lane_t a;
		rx_intf_pkg::lane_t b;
		logic signed [rx_intf_pkg::LANE_W:0] sum;

		assign a   = a0_flat[l*rx_intf_pkg::LANE_W +: rx_intf_pkg::LANE_W];
		assign b   = a1_flat[l*rx_intf_pkg::LANE_W +: rx_intf_pkg::LANE_W];
		assign sum = a + b;
		assign avg_word[l*rx_intf_pkg::LANE_W +: rx_intf_pkg::LANE_W] =
			rx_intf_pkg::LANE_W'(sum >>> 1);
	end

	assign drain = out_valid && acc_ask_data;

	// Refill in the same cycle the accelerator drains.
	assign load     = !a0_empty && !a1_empty && (!out_valid || drain);
	assign a0_rd_en = load;
	assign a1_rd_en = load;

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
			out_valid <= 1'b0;
		else if (load)
			out_valid <= 1'b1;
		else if (drain)
			out_valid <= 1'b0;
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (load)
			data_to_acc <= avg_word;
	end

	assign emptyn_to_acc = out_valid;
	assign word_taken    = drain;

endmodule

//--- rtl/rx_intf_wb_regs.sv
/* Wishbone classic register file: control, symbol count and delivered-word counter. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_intf_wb_regs
(
	input  logic                 S_AXIS_ACLK,
	input  logic                 S_AXIS_ARESETN,
	input  logic                 wb_cyc,
	input  logic                 wb_stb,
	input  logic                 wb_we,
	input  logic [3:0]           wb_adr,
	input  logic [31:0]          wb_dat_w,
	input  logic                 word_taken,
	output logic [31:0]          wb_dat_r,
	output logic                 wb_ack,
	output logic                 endless_mode,
	output logic [`RX_CNT_W-1:0] num_dma_symbol
);
	logic        req;
	logic        access;
	logic [31:0] delivered;
	logic [31:0] rd_mux;

	assign req = wb_cyc && wb_stb;

	// Ack is a single pulse, then low for a cycle.
	assign access = req && !wb_ack;

	always_comb
	begin
		case (wb_adr)
			`RX_REG_CTRL:      rd_mux = {31'b0, endless_mode};
			`RX_REG_NUM_SYM:   rd_mux = {{(32 - `RX_CNT_W){1'b0}}, num_dma_symbol};
			`RX_REG_DELIVERED: rd_mux = delivered;
			default:           rd_mux = '0;
		endcase
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			wb_ack         <= 1'b0;
			endless_mode   <= 1'b0;
			num_dma_symbol <= '0;
		end
		else
		begin
			wb_ack <= access;
			if (access && wb_we && wb_adr == `RX_REG_CTRL)
				endless_mode <= wb_dat_w[0];
			if (access && wb_we && wb_adr == `RX_REG_NUM_SYM)
				num_dma_symbol <= wb_dat_w[`RX_CNT_W-1:0];
		end
	end

	// Any write clears the counter, and wins over a word taken that cycle.
	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
			delivered <= '0;
		else if (access && wb_we && wb_adr == `RX_REG_DELIVERED)
			delivered <= '0;
		else if (word_taken)
			delivered <= delivered + 1'b1;
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (access)
			wb_dat_r <= rd_mux;
	end

endmodule

//--- rtl/rx_intf_s_axis.sv
/* AXI-Stream slave burst controller feeding one antenna FIFO. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_intf_s_axis
(
	input  logic                       S_AXIS_ACLK,
	input  logic                       S_AXIS_ARESETN,
	input  logic                       endless_mode,
	input  logic [`RX_CNT_W-1:0]       num_dma_symbol,
	input  rx_intf_pkg::rx_word_t      tdata,
	input  logic [`RX_DATA_W/8-1:0]    tstrb,
	input  logic                       tlast,
	input  logic                       tvalid,
	input  logic                       fifo_full,
	output logic                       tready,
	output logic                       fifo_wren,
	output rx_intf_pkg::rx_word_t      fifo_din
);
	localparam logic IDLE  = 1'b0;
	localparam logic WRITE = 1'b1;

	logic                 state;
	logic [`RX_CNT_W-1:0] beat_cnt;
	logic [`RX_CNT_W-1:0] beat_cnt_inc;
	logic                 at_limit;
	logic                 last_counted;
	logic                 burst_done;

	assign beat_cnt_inc = beat_cnt + 1'b1;
	assign at_limit     = !endless_mode && (beat_cnt == num_dma_symbol);
	assign last_counted = !endless_mode && (beat_cnt_inc == num_dma_symbol);

	// A full FIFO holds off the master in the same cycle.
	assign tready    = (state == WRITE) && !at_limit && !fifo_full;
	assign fifo_wren = tvalid && tready;

	// Byte strobes are ignored and every beat is stored whole.
	assign fifo_din = tdata;

	// Limit already reached covers a zero or lowered symbol count.
	assign burst_done = at_limit || (fifo_wren && (tlast || last_counted));

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			state    <= IDLE;
			beat_cnt <= '0;
		end
		else if (state == IDLE)
		begin
			beat_cnt <= '0;
			if (tvalid)
				state <= WRITE;
		end
		else if (burst_done)
		begin
			state    <= IDLE;
			beat_cnt <= '0;
		end
		else if (fifo_wren)
			beat_cnt <= beat_cnt_inc;
	end

endmodule

//--- rtl/rx_sync_fifo.sv
/* Single-clock first-word-fall-through FIFO with occupancy count. */

`timescale 1ns/1ps

`include "rx_intf_params.svh"

module rx_sync_fifo #(
	parameter integer DEPTH = `RX_FIFO_DEPTH,
	parameter integer WIDTH = `RX_DATA_W
)
(
	input  logic                 S_AXIS_ACLK,
	input  logic                 S_AXIS_ARESETN,
	input  logic                 wr_en,
	input  logic [WIDTH-1:0]     din,
	input  logic                 rd_en,
	output logic [WIDTH-1:0]     dout,
	output logic                 empty,
	output logic                 full,
	output logic [`RX_CNT_W-1:0] data_count
);
	localparam integer PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]     mem [DEPTH];
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic [`RX_CNT_W-1:0] count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		ptr_next = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge S_AXIS_ACLK)
	begin
		if (!S_AXIS_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= ptr_next(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_next(rd_ptr);
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head word is visible as soon as it is written.
	assign dout       = mem[rd_ptr];
	assign empty      = (count == '0);
	assign full       = (count == `RX_CNT_W'(DEPTH));
	assign data_count = count;

endmodule

//--- rtl/rx_intf_pkg.sv
/* Sample, lane and stream word types shared by the receive path. */

`include "rx_intf_params.svh"

package rx_intf_pkg;

	// One real or imaginary part.
	localparam int LANE_W = 16;

	// 16-bit lanes per stream word.
	localparam int LANES = `RX_DATA_W / LANE_W;

	typedef logic signed [LANE_W-1:0] lane_t;

	// I in the low half, Q in the high half.
	typedef logic [2*LANE_W-1:0] iq_sample_t;

	// Sample 0 sits in the low 32 bits.
	typedef iq_sample_t [`RX_DATA_W/(2*LANE_W)-1:0] rx_word_t;

endpackage

//--- rtl/rx_intf_params.svh
/* Stream width, FIFO depth, count width and Wishbone register addresses. */

`ifndef RX_INTF_PARAMS_SVH
`define RX_INTF_PARAMS_SVH

// One AXI-Stream beat carries two complex samples.
`define RX_DATA_W 64

// Words per antenna FIFO.
`define RX_FIFO_DEPTH 16

// Width of the symbol count and of the FIFO occupancy.
`define RX_CNT_W 14

// Wishbone word addresses.
`define RX_REG_CTRL      4'd0
`define RX_REG_NUM_SYM   4'd1
`define RX_REG_DELIVERED 4'd2

`endif
